// ==== include/addrgen_settings.svh ====
/* Bus, vector length and command queue sizes of the address generator.
   Included by the packages, the RTL modules that size logic from it and the testbench */
`ifndef ADDRGEN_SETTINGS_SVH
`define ADDRGEN_SETTINGS_SVH

// Byte address width on AR/AW and in the command queue
`define ADDRGEN_ADDR_W 32

// Data bus of the memory side, 8 bytes wide
`define ADDRGEN_BUS_BYTES 8
// Must stay equal to log2 of ADDRGEN_BUS_BYTES
`define ADDRGEN_BUS_BYTES_LOG 3

// Element count of one vector request
`define ADDRGEN_VL_W 8

// Entries of the load/store command queue, also the initial credit count
`define ADDRGEN_QUEUE_DEPTH 4

`endif

// ==== hw/vmem_pkg.sv ====
/* Types of the vector memory request as it enters the address generator.
   Imported by the request decoder, the burst generator and the top level */
`include "addrgen_settings.svh"

package vmem_pkg;

  // Vector memory operation kinds that are supported
  typedef enum logic [1:0] {
    OP_UNIT_LOAD    = 2'd0,
    OP_UNIT_STORE   = 2'd1,
    OP_STRIDE_LOAD  = 2'd2,
    OP_STRIDE_STORE = 2'd3
  } vmem_op_e;

  // Element width, encoded as log2 of the element byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Number of elements in one request
  typedef logic [`ADDRGEN_VL_W-1:0] vlen_t;
  // Byte distance between strided elements
  typedef logic [`ADDRGEN_ADDR_W-1:0] stride_t;

  // Request decoder FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_CHECK,
    DEC_ISSUE
  } dec_state_e;

endpackage

// ==== hw/axi_cmd_pkg.sv ====
/* Types of the AR/AW address beats and of the load/store commands built from them.
   Imported by the burst generator, the command queue and the top level */
`include "addrgen_settings.svh"

package axi_cmd_pkg;

  // Byte address of a beat
  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;

  // AXI burst length, number of beats minus one
  typedef logic [7:0] ax_len_t;

  // AXI size, log2 of the bytes per beat
  typedef logic [2:0] ax_size_t;

  // Queue credits, wide enough for a completely free queue
  typedef logic [$clog2(`ADDRGEN_QUEUE_DEPTH+1)-1:0] credit_t;

  // Burst generator FSM
  typedef enum logic [1:0] {
    BG_IDLE,
    BG_WIDTH,
    BG_ISSUE
  } burst_state_e;

endpackage

// ==== hw/vmem_req_decoder.sv ====
/* Captures one vector memory request, checks element alignment and either rejects it
   or holds a descriptor for the burst generator until the last beat is issued */
`timescale 1ns/100ps

module vmem_req_decoder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request side
  input  logic                 req_valid_i,
  input  vmem_pkg::vmem_op_e   req_op_i,
  input  axi_cmd_pkg::addr_t   req_addr_i,
  input  vmem_pkg::vlen_t      req_vl_i,
  input  vmem_pkg::vew_e       req_vew_i,
  input  vmem_pkg::stride_t    req_stride_i,
  output logic                 ack_o,
  output logic                 error_o,
  // Descriptor towards the burst generator
  output logic                 desc_valid_o,
  output axi_cmd_pkg::addr_t   desc_addr_o,
  output vmem_pkg::vlen_t      desc_vl_o,
  output vmem_pkg::vew_e       desc_vew_o,
  output vmem_pkg::stride_t    desc_stride_o,
  output logic                 desc_is_load_o,
  output logic                 desc_is_burst_o,
  input  logic                 desc_done_i
);
  import vmem_pkg::*;
  import axi_cmd_pkg::*;

  dec_state_e state_q, state_d;

  // Captured request
  vmem_op_e op_q;
  addr_t    addr_q;
  vlen_t    vl_q;
  vew_e     vew_q;
  stride_t  stride_q;

  logic     capture;
  logic     misaligned;

  assign capture = (state_q == DEC_IDLE) && req_valid_i;

  // Element alignment, the low vew address bits must be zero
  always_comb begin
    unique case (vew_q)
      EW8:     misaligned = 1'b0;
      EW16:    misaligned = addr_q[0];
      EW32:    misaligned = |addr_q[1:0];
      default: misaligned = |addr_q[2:0];
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  always_comb begin
    state_d = state_q;
    ack_o   = 1'b0;
    error_o = 1'b0;
    unique case (state_q)
      DEC_IDLE: begin
        if (req_valid_i) begin
          state_d = DEC_CHECK;
        end
      end
      DEC_CHECK: begin
        // Bad request is answered right away, nothing reaches AR/AW
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = DEC_IDLE;
        end else begin
          state_d = DEC_ISSUE;
        end
      end
      DEC_ISSUE: begin
        // Ack coincides with the last beat
        if (desc_done_i) begin
          ack_o   = 1'b1;
          state_d = DEC_IDLE;
        end
      end
      default: state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DEC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      op_q     <= req_op_i;
      addr_q   <= req_addr_i;
      vl_q     <= req_vl_i;
      vew_q    <= req_vew_i;
      stride_q <= req_stride_i;
    end
  end

  // Descriptor stays stable for the whole issue phase
  assign desc_valid_o    = (state_q == DEC_ISSUE);
  assign desc_addr_o     = addr_q;
  assign desc_vl_o       = vl_q;
  assign desc_vew_o      = vew_q;
  assign desc_stride_o   = stride_q;
  assign desc_is_load_o  = (op_q == OP_UNIT_LOAD) || (op_q == OP_STRIDE_LOAD);
  assign desc_is_burst_o = (op_q == OP_UNIT_LOAD) || (op_q == OP_UNIT_STORE);

  ////////////////////////////////////////////////////////////////////////////
  // Requester obligations
  a_vl_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    capture |-> (req_vl_i != '0));

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !ack_o |=> req_valid_i &&
      $stable({req_op_i, req_addr_i, req_vl_i, req_vew_i, req_stride_i}));

endmodule

// ==== hw/ax_burst_gen.sv ====
/* Turns a decoded descriptor into AR or AW beats and pushes a copy of each beat
   into the command queue, under credit flow control and the channel ordering rule */
`timescale 1ns/100ps
`include "addrgen_settings.svh"

module ax_burst_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Descriptor from the decoder
  input  logic                   desc_valid_i,
  input  axi_cmd_pkg::addr_t     desc_addr_i,
  input  vmem_pkg::vlen_t        desc_vl_i,
  input  vmem_pkg::vew_e         desc_vew_i,
  input  vmem_pkg::stride_t      desc_stride_i,
  input  logic                   desc_is_load_i,
  input  logic                   desc_is_burst_i,
  output logic                   desc_done_o,
  // AR channel
  output logic                   ar_valid_o,
  output axi_cmd_pkg::addr_t     ar_addr_o,
  output axi_cmd_pkg::ax_len_t   ar_len_o,
  output axi_cmd_pkg::ax_size_t  ar_size_o,
  input  logic                   ar_ready_i,
  // AW channel
  output logic                   aw_valid_o,
  output axi_cmd_pkg::addr_t     aw_addr_o,
  output axi_cmd_pkg::ax_len_t   aw_len_o,
  output axi_cmd_pkg::ax_size_t  aw_size_o,
  input  logic                   aw_ready_i,
  // Command queue
  output logic                   push_o,
  output axi_cmd_pkg::addr_t     push_addr_o,
  output axi_cmd_pkg::ax_len_t   push_len_o,
  output axi_cmd_pkg::ax_size_t  push_size_o,
  output logic                   push_is_load_o,
  input  logic                   credit_i,
  input  logic                   head_valid_i,
  input  logic                   head_is_load_i
);
  import vmem_pkg::*;
  import axi_cmd_pkg::*;

  localparam credit_t max_credits = credit_t'(`ADDRGEN_QUEUE_DEPTH);

  burst_state_e state_q, state_d;
  credit_t      credits_q;

  // Running beat address and elements still to issue
  addr_t    addr_q;
  vlen_t    left_q;
  ax_len_t  len_q;
  ax_size_t size_q;

  logic [`ADDRGEN_BUS_BYTES_LOG-1:0] bus_off;
  logic [`ADDRGEN_VL_W+2:0]          byte_cnt;
  ax_size_t                          eff_size;
  logic ord_block, can_issue, ch_ready, fire, last_beat;

  ////////////////////////////////////////////////////////////////////////////
  // Effective beat width
  assign bus_off  = addr_q[`ADDRGEN_BUS_BYTES_LOG-1:0];
  // Total bytes of a unit-stride access
  assign byte_cnt = {3'b000, desc_vl_i} << desc_vew_i;

  // Stores off the bus grid shrink to the largest power of two the offset allows
  always_comb begin
    eff_size = ax_size_t'(`ADDRGEN_BUS_BYTES_LOG);
    if (!desc_is_load_i) begin
      // Lowest set bit wins, so scan from the top down
      for (int i = `ADDRGEN_BUS_BYTES_LOG-1; i >= 0; i--) begin
        if (bus_off[i]) begin
          eff_size = ax_size_t'(i);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue conditions
  // Wait while the queue head is a command of the other kind
  assign ord_block   = head_valid_i && (head_is_load_i != desc_is_load_i);
  assign can_issue   = (state_q == BG_ISSUE) && (credits_q != '0) && !ord_block;
  assign ch_ready    = desc_is_load_i ? ar_ready_i : aw_ready_i;
  assign fire        = can_issue && ch_ready;
  assign last_beat   = desc_is_burst_i || (left_q == vlen_t'(1));
  assign desc_done_o = fire && last_beat;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BG_IDLE: begin
        if (desc_valid_i) begin
          state_d = BG_WIDTH;
        end
      end
      BG_WIDTH: state_d = BG_ISSUE;
      BG_ISSUE: begin
        if (desc_done_o) begin
          state_d = BG_IDLE;
        end
      end
      default: state_d = BG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BG_IDLE;
      credits_q <= max_credits;
    end else begin
      state_q   <= state_d;
      // One credit back per pop, one spent per push
      credits_q <= credits_q + credit_t'(credit_i) - credit_t'(push_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == BG_IDLE) && desc_valid_i) begin
      addr_q <= desc_addr_i;
      left_q <= desc_vl_i;
    end else if (fire) begin
      addr_q <= addr_q + desc_stride_i;
      left_q <= left_q - vlen_t'(1);
    end
    // Burst len is the beat count minus one, rounded up to whole beats
    if (state_q == BG_WIDTH) begin
      if (desc_is_burst_i) begin
        size_q <= eff_size;
        len_q  <= ax_len_t'((byte_cnt - 1'b1) >> eff_size);
      end else begin
        // Strided beats carry a single element
        size_q <= ax_size_t'(desc_vew_i);
        len_q  <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel and queue outputs
  assign ar_valid_o     = can_issue && desc_is_load_i;
  assign ar_addr_o      = addr_q;
  assign ar_len_o       = len_q;
  assign ar_size_o      = size_q;
  assign aw_valid_o     = can_issue && !desc_is_load_i;
  assign aw_addr_o      = addr_q;
  assign aw_len_o       = len_q;
  assign aw_size_o      = size_q;

  assign push_o         = fire;
  assign push_addr_o    = addr_q;
  assign push_len_o     = len_q;
  assign push_size_o    = size_q;
  assign push_is_load_o = desc_is_load_i;

  // Queue only returns credits it was given
  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credits_q <= max_credits);

endmodule

// ==== hw/lsu_cmd_queue.sv ====
/* Circular command FIFO between the burst generator and the load/store unit.
   Every pop returns one credit to the burst generator */
`timescale 1ns/100ps
`include "addrgen_settings.svh"

module lsu_cmd_queue #(
  parameter int unsigned depth = `ADDRGEN_QUEUE_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  axi_cmd_pkg::addr_t     push_addr_i,
  input  axi_cmd_pkg::ax_len_t   push_len_i,
  input  axi_cmd_pkg::ax_size_t  push_size_i,
  input  logic                   push_is_load_i,
  output logic                   cmd_valid_o,
  output axi_cmd_pkg::addr_t     cmd_addr_o,
  output axi_cmd_pkg::ax_len_t   cmd_len_o,
  output axi_cmd_pkg::ax_size_t  cmd_size_o,
  output logic                   cmd_is_load_o,
  input  logic                   cmd_pop_i,
  output logic                   credit_o
);
  import axi_cmd_pkg::*;

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // Storage
  addr_t    addr_mem [depth];
  ax_len_t  len_mem  [depth];
  ax_size_t size_mem [depth];
  logic     load_mem [depth];

  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic full, wr_en, rd_en;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == cnt_w'(depth));
  assign cmd_valid_o = (count_q != '0);
  assign wr_en       = push_i && !full;
  assign rd_en       = cmd_pop_i && cmd_valid_o;
  assign credit_o    = rd_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + cnt_w'(wr_en) - cnt_w'(rd_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      len_mem[wr_ptr_q]  <= push_len_i;
      size_mem[wr_ptr_q] <= push_size_i;
      load_mem[wr_ptr_q] <= push_is_load_i;
    end
  end

  // Head entry
  assign cmd_addr_o    = addr_mem[rd_ptr_q];
  assign cmd_len_o     = len_mem[rd_ptr_q];
  assign cmd_size_o    = size_mem[rd_ptr_q];
  assign cmd_is_load_o = load_mem[rd_ptr_q];

  // Credit scheme upstream must keep the queue from overflowing
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full);

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_pop_i |-> cmd_valid_o);

endmodule

// ==== hw/addrgen_top.sv ====
/* Vector load/store address generator top level.
   Connects the request decoder, the AR/AW burst generator and the command queue */
`timescale 1ns/100ps

module addrgen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Vector memory request
  input  logic                   req_valid_i,
  input  vmem_pkg::vmem_op_e     req_op_i,
  input  axi_cmd_pkg::addr_t     req_addr_i,
  input  vmem_pkg::vlen_t        req_vl_i,
  input  vmem_pkg::vew_e         req_vew_i,
  input  vmem_pkg::stride_t      req_stride_i,
  output logic                   ack_o,
  output logic                   error_o,
  // AR channel
  output logic                   ar_valid_o,
  output axi_cmd_pkg::addr_t     ar_addr_o,
  output axi_cmd_pkg::ax_len_t   ar_len_o,
  output axi_cmd_pkg::ax_size_t  ar_size_o,
  input  logic                   ar_ready_i,
  // AW channel
  output logic                   aw_valid_o,
  output axi_cmd_pkg::addr_t     aw_addr_o,
  output axi_cmd_pkg::ax_len_t   aw_len_o,
  output axi_cmd_pkg::ax_size_t  aw_size_o,
  input  logic                   aw_ready_i,
  // Commands to the load/store unit
  output logic                   cmd_valid_o,
  output axi_cmd_pkg::addr_t     cmd_addr_o,
  output axi_cmd_pkg::ax_len_t   cmd_len_o,
  output axi_cmd_pkg::ax_size_t  cmd_size_o,
  output logic                   cmd_is_load_o,
  input  logic                   cmd_pop_i
);
  import vmem_pkg::*;
  import axi_cmd_pkg::*;

  // Decoder to burst generator
  logic     desc_valid, desc_is_load, desc_is_burst, desc_done;
  addr_t    desc_addr;
  vlen_t    desc_vl;
  vew_e     desc_vew;
  stride_t  desc_stride;

  // Burst generator to queue
  logic     push, push_is_load, credit;
  addr_t    push_addr;
  ax_len_t  push_len;
  ax_size_t push_size;

  vmem_req_decoder i_decoder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_vl_i        (req_vl_i),
    .req_vew_i       (req_vew_i),
    .req_stride_i    (req_stride_i),
    .ack_o           (ack_o),
    .error_o         (error_o),
    .desc_valid_o    (desc_valid),
    .desc_addr_o     (desc_addr),
    .desc_vl_o       (desc_vl),
    .desc_vew_o      (desc_vew),
    .desc_stride_o   (desc_stride),
    .desc_is_load_o  (desc_is_load),
    .desc_is_burst_o (desc_is_burst),
    .desc_done_i     (desc_done)
  );

  // Queue head feeds back for the ordering rule
  ax_burst_gen i_burst_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .desc_valid_i    (desc_valid),
    .desc_addr_i     (desc_addr),
    .desc_vl_i       (desc_vl),
    .desc_vew_i      (desc_vew),
    .desc_stride_i   (desc_stride),
    .desc_is_load_i  (desc_is_load),
    .desc_is_burst_i (desc_is_burst),
    .desc_done_o     (desc_done),
    .ar_valid_o      (ar_valid_o),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .ar_ready_i      (ar_ready_i),
    .aw_valid_o      (aw_valid_o),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .aw_ready_i      (aw_ready_i),
    .push_o          (push),
    .push_addr_o     (push_addr),
    .push_len_o      (push_len),
    .push_size_o     (push_size),
    .push_is_load_o  (push_is_load),
    .credit_i        (credit),
    .head_valid_i    (cmd_valid_o),
    .head_is_load_i  (cmd_is_load_o)
  );

  lsu_cmd_queue i_cmd_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_addr_i    (push_addr),
    .push_len_i     (push_len),
    .push_size_i    (push_size),
    .push_is_load_i (push_is_load),
    .cmd_valid_o    (cmd_valid_o),
    .cmd_addr_o     (cmd_addr_o),
    .cmd_len_o      (cmd_len_o),
    .cmd_size_o     (cmd_size_o),
    .cmd_is_load_o  (cmd_is_load_o),
    .cmd_pop_i      (cmd_pop_i),
    .credit_o       (credit)
  );

endmodule

// ==== include/tb_addrgen_checks.svh ====
/* Typed compare tasks and check counters of the address generator testbench.
   Included inside the testbench module, after the package imports */
`ifndef TB_ADDRGEN_CHECKS_SVH
`define TB_ADDRGEN_CHECKS_SVH

int unsigned check_cnt = 0;
int unsigned err_cnt   = 0;

// Protocol or timeout failure without a single wrong value
task automatic note_failure(input string what);
  err_cnt++;
  $display("t=%0t %s", $time, what);
endtask

// One AR or AW beat compared field by field
task automatic check_beat(input string chan,
                          input addr_t got_addr, input addr_t exp_addr,
                          input ax_len_t got_len, input ax_len_t exp_len,
                          input ax_size_t got_size, input ax_size_t exp_size);
  check_cnt++;
  if (got_addr !== exp_addr) begin
    err_cnt++;
    $display("ERR t=%0t %s_addr_o got 0x%08h exp 0x%08h", $time, chan, got_addr, exp_addr);
  end
  if (got_len !== exp_len) begin
    err_cnt++;
    $display("ERR t=%0t %s_len_o got %0d exp %0d", $time, chan, got_len, exp_len);
  end
  if (got_size !== exp_size) begin
    err_cnt++;
    $display("ERR t=%0t %s_size_o got %0d exp %0d", $time, chan, got_size, exp_size);
  end
endtask

// Head of the command queue at a pop
task automatic check_cmd(input addr_t got_addr, input addr_t exp_addr,
                         input ax_len_t got_len, input ax_len_t exp_len,
                         input ax_size_t got_size, input ax_size_t exp_size,
                         input logic got_load, input logic exp_load);
  check_cnt++;
  if (got_addr !== exp_addr) begin
    err_cnt++;
    $display("ERR t=%0t cmd_addr_o got 0x%08h exp 0x%08h", $time, got_addr, exp_addr);
  end
  if (got_len !== exp_len) begin
    err_cnt++;
    $display("ERR t=%0t cmd_len_o got %0d exp %0d", $time, got_len, exp_len);
  end
  if (got_size !== exp_size) begin
    err_cnt++;
    $display("ERR t=%0t cmd_size_o got %0d exp %0d", $time, got_size, exp_size);
  end
  if (got_load !== exp_load) begin
    err_cnt++;
    $display("ERR t=%0t cmd_is_load_o got %0b exp %0b", $time, got_load, exp_load);
  end
endtask

// Error flag in the ack cycle
task automatic check_ack(input logic got_error, input logic exp_error);
  check_cnt++;
  if (got_error !== exp_error) begin
    err_cnt++;
    $display("ERR t=%0t error_o got %0b exp %0b", $time, got_error, exp_error);
  end
endtask

// Queue occupancy seen at cmd_valid_o
task automatic check_cmd_valid(input logic got_valid, input logic exp_valid);
  check_cnt++;
  if (got_valid !== exp_valid) begin
    err_cnt++;
    $display("ERR t=%0t cmd_valid_o got %0b exp %0b", $time, got_valid, exp_valid);
  end
endtask

`endif

// ==== tb/tb_addrgen.sv ====
/* Testbench of the vector address generator. Directed and random requests run against
   a beat model, with a scoreboard on AR/AW, on the command queue and on ack/error */
`timescale 1ns/100ps

module tb_addrgen;
  import vmem_pkg::*;
  import axi_cmd_pkg::*;

  `include "tb_addrgen_checks.svh"

  localparam int unsigned ack_timeout   = 2000;
  localparam int unsigned drain_timeout = 500;
  localparam int unsigned random_reqs   = 200;

  logic     clk_i;
  logic     rst_ni;
  logic     req_valid_i;
  vmem_op_e req_op_i;
  addr_t    req_addr_i;
  vlen_t    req_vl_i;
  vew_e     req_vew_i;
  stride_t  req_stride_i;
  logic     ack_o, error_o;
  logic     ar_valid_o, aw_valid_o;
  logic     ar_ready_i = 1'b0;
  logic     aw_ready_i = 1'b0;
  addr_t    ar_addr_o, aw_addr_o, cmd_addr_o;
  ax_len_t  ar_len_o, aw_len_o, cmd_len_o;
  ax_size_t ar_size_o, aw_size_o, cmd_size_o;
  logic     cmd_valid_o, cmd_is_load_o;
  logic     cmd_pop_i = 1'b0;

  // Expected beats of the request in flight
  addr_t    beat_addr_q[$];
  ax_len_t  beat_len_q[$];
  ax_size_t beat_size_q[$];
  logic     beat_load_q[$];
  // Accepted beats still held by the command queue
  addr_t    cmd_addr_q[$];
  ax_len_t  cmd_len_q[$];
  ax_size_t cmd_size_q[$];
  logic     cmd_load_q[$];

  // Request draws and back-pressure draws come from separate streams
  logic [31:0] req_rng;
  logic [31:0] bp_rng = 32'h997;
  logic        bp_on;
  logic        timed_out;
  int unsigned test_cnt;

  addrgen_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic logic elem_misaligned(input addr_t addr, input vew_e vew);
    return (addr & ((32'd1 << vew) - 32'd1)) != 32'd0;
  endfunction

  // Full bus for loads and bus aligned stores, else the largest power of two
  // dividing the base address
  function automatic ax_size_t unit_beat_size(input logic is_load, input addr_t addr);
    if (is_load || (addr[2:0] == 3'b000)) begin
      return 3'd3;
    end
    if (addr[0]) begin
      return 3'd0;
    end
    if (addr[1]) begin
      return 3'd1;
    end
    return 3'd2;
  endfunction

  // Beats needed to cover vl elements minus one
  function automatic ax_len_t unit_beat_len(input vlen_t vl, input vew_e vew,
                                            input ax_size_t size);
    int unsigned bytes;
    int unsigned beat_bytes;
    bytes      = 32'(vl) << vew;
    beat_bytes = 32'd1 << size;
    return ax_len_t'((bytes + beat_bytes - 32'd1) / beat_bytes - 32'd1);
  endfunction

  task automatic expect_beats(input vmem_op_e op, input addr_t addr, input vlen_t vl,
                              input vew_e vew, input stride_t stride);
    logic     is_load;
    ax_size_t size;
    is_load = (op == OP_UNIT_LOAD) || (op == OP_STRIDE_LOAD);
    if ((op == OP_UNIT_LOAD) || (op == OP_UNIT_STORE)) begin
      size = unit_beat_size(is_load, addr);
      beat_addr_q.push_back(addr);
      beat_len_q.push_back(unit_beat_len(vl, vew, size));
      beat_size_q.push_back(size);
      beat_load_q.push_back(is_load);
    end else begin
      // One element per beat with the k-th at base plus k strides
      for (int k = 0; k < int'(vl); k++) begin
        beat_addr_q.push_back(addr + addr_t'(k) * stride);
        beat_len_q.push_back(8'd0);
        beat_size_q.push_back(ax_size_t'(vew));
        beat_load_q.push_back(is_load);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pops are drawn only while the queue holds a command in the next cycle
  always @(posedge clk_i) begin
    bp_rng = xorshift32(bp_rng);
    if (bp_on) begin
      ar_ready_i <= bp_rng[0] | bp_rng[1];
      aw_ready_i <= bp_rng[2] | bp_rng[3];
      cmd_pop_i  <= (cmd_addr_q.size() != 0) && bp_rng[4];
    end else begin
      ar_ready_i <= 1'b1;
      aw_ready_i <= 1'b1;
      cmd_pop_i  <= (cmd_addr_q.size() != 0);
    end
  end

  task automatic accept_beat(input logic is_load, input addr_t addr, input ax_len_t len,
                             input ax_size_t size);
    string chan;
    chan = is_load ? "ar" : "aw";
    if (cmd_valid_o && (cmd_is_load_o != is_load)) begin
      note_failure("beat accepted while the queue holds commands of the other kind");
    end
    if (beat_addr_q.size() == 0) begin
      note_failure("beat accepted while no beat was expected");
      // Stray beat still occupies a queue entry
      cmd_addr_q.push_back(addr);
      cmd_len_q.push_back(len);
      cmd_size_q.push_back(size);
      cmd_load_q.push_back(is_load);
    end else begin
      if (beat_load_q[0] != is_load) begin
        note_failure("beat issued on the wrong channel");
      end
      check_beat(chan, addr, beat_addr_q[0], len, beat_len_q[0], size, beat_size_q[0]);
      // Queue must replay accepted beats in order
      cmd_addr_q.push_back(beat_addr_q[0]);
      cmd_len_q.push_back(beat_len_q[0]);
      cmd_size_q.push_back(beat_size_q[0]);
      cmd_load_q.push_back(beat_load_q[0]);
      void'(beat_addr_q.pop_front());
      void'(beat_len_q.pop_front());
      void'(beat_size_q.pop_front());
      void'(beat_load_q.pop_front());
    end
  endtask

  // Scoreboard samples mid-cycle where every handshake is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_cmd_valid(cmd_valid_o, cmd_addr_q.size() != 0);
      if (cmd_pop_i && cmd_valid_o && (cmd_addr_q.size() != 0)) begin
        check_cmd(cmd_addr_o, cmd_addr_q[0], cmd_len_o, cmd_len_q[0],
                  cmd_size_o, cmd_size_q[0], cmd_is_load_o, cmd_load_q[0]);
        void'(cmd_addr_q.pop_front());
        void'(cmd_len_q.pop_front());
        void'(cmd_size_q.pop_front());
        void'(cmd_load_q.pop_front());
      end
      if (ar_valid_o && ar_ready_i) begin
        accept_beat(1'b1, ar_addr_o, ar_len_o, ar_size_o);
      end
      if (aw_valid_o && aw_ready_i) begin
        accept_beat(1'b0, aw_addr_o, aw_len_o, aw_size_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request sequencing
  task automatic run_request(input vmem_op_e op, input addr_t addr, input vlen_t vl,
                             input vew_e vew, input stride_t stride);
    logic        exp_err;
    int unsigned cycles;
    if (timed_out) begin
      return;
    end
    exp_err = elem_misaligned(addr, vew);
    if (!exp_err) begin
      expect_beats(op, addr, vl, vew, stride);
    end
    @(posedge clk_i);
    req_valid_i  <= 1'b1;
    req_op_i     <= op;
    req_addr_i   <= addr;
    req_vl_i     <= vl;
    req_vew_i    <= vew;
    req_stride_i <= stride;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!ack_o && (cycles < ack_timeout));
    if (!ack_o) begin
      note_failure("no ack_o within the timeout");
      timed_out = 1'b1;
    end else begin
      check_ack(error_o, exp_err);
    end
    // Request is withdrawn once the ack cycle ends
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    if (beat_addr_q.size() != 0) begin
      note_failure("expected beats still missing after ack_o");
      beat_addr_q.delete();
      beat_len_q.delete();
      beat_size_q.delete();
      beat_load_q.delete();
    end
  endtask

  task automatic random_request();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] eb;
    vew_e        vew;
    addr_t       addr;
    req_rng = xorshift32(req_rng);
    r       = req_rng;
    req_rng = xorshift32(req_rng);
    a       = req_rng;
    vew     = vew_e'(r[3:2]);
    eb      = 32'd1 << vew;
    addr    = a & ~(eb - 32'd1);
    // About one wide request in four gets a misaligned base
    if ((vew != EW8) && (r[5:4] == 2'b00)) begin
      addr = addr | (32'd1 + (a % (eb - 32'd1)));
    end
    run_request(vmem_op_e'(r[1:0]), addr, vlen_t'(32'd1 + (32'(r[15:8]) % 32'd40)),
                vew, stride_t'(32'(r[19:16]) * eb));
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    if (timed_out) begin
      return;
    end
    cycles = 0;
    while ((cmd_addr_q.size() != 0) && (cycles < drain_timeout)) begin
      @(posedge clk_i);
      cycles++;
    end
    if (cmd_addr_q.size() != 0) begin
      note_failure("command queue did not drain within the timeout");
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
  endtask

  initial begin
    int unsigned errs;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = OP_UNIT_LOAD;
    req_addr_i   = '0;
    req_vl_i     = 8'd1;
    req_vew_i    = EW8;
    req_stride_i = '0;
    req_rng      = 32'h997;
    bp_on        = 1'b0;
    timed_out    = 1'b0;
    test_cnt     = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Aligned unit-stride load of 40 bytes in 5 full beats
    errs = err_cnt;
    run_request(OP_UNIT_LOAD, 32'h0000_1000, 8'd10, EW32, '0);
    end_test("unit-stride load", errs);

    // Store off the bus grid narrows to 2-byte beats
    errs = err_cnt;
    run_request(OP_UNIT_STORE, 32'h0000_2006, 8'd7, EW16, '0);
    end_test("narrowed unit-stride store", errs);

    errs = err_cnt;
    run_request(OP_STRIDE_LOAD, 32'h0000_3000, 8'd5, EW32, 32'd12);
    run_request(OP_STRIDE_STORE, 32'h0000_4002, 8'd4, EW16, 32'd6);
    end_test("strided load and store", errs);

    errs = err_cnt;
    run_request(OP_UNIT_LOAD, 32'h0000_5002, 8'd3, EW32, '0);
    run_request(OP_STRIDE_STORE, 32'h0000_6004, 8'd2, EW64, 32'd8);
    end_test("element misaligned", errs);

    errs = err_cnt;
    @(negedge clk_i);
    bp_on = 1'b1;
    for (int n = 0; n < int'(random_reqs); n++) begin
      random_request();
    end
    wait_drain();
    end_test("random back-pressure", errs);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== addrgen_top.f ====
+incdir+include
hw/vmem_pkg.sv
hw/axi_cmd_pkg.sv
hw/vmem_req_decoder.sv
hw/ax_burst_gen.sv
hw/lsu_cmd_queue.sv
hw/addrgen_top.sv
tb/tb_addrgen.sv

// ==== Makefile ====
FLIST := addrgen_top.f
LOG   := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module addrgen_top -f $(FLIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_addrgen \
	  -f $(FLIST) -Mdir obj_dir -o sim_addrgen
	./obj_dir/sim_addrgen > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
